//--- sources.f
f2_pkg.sv
f2_bus_decode.sv
f2_work_ram.sv
f2_input_ports.sv
f2_irq_ctrl.sv
f2_palette.sv
f2_cpu_response.sv
f2_top.sv
tb_clock.sv
f2_assert.sv
f2_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= f2_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= Test completed successfully

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	@out="$$($(SIM_BIN) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- f2_tb.sv
`timescale 1ns/1ns
`default_nettype none

module f2_tb;

import f2_pkg::*;

typedef logic [PAL_AW_DEF-1:0] pal_index_t;

localparam int         TIMEOUT   = 40;    // Clocks per wait
localparam logic [7:0] NONE_BASE = 8'h50; // Nothing mapped here

logic        clk;
logic        reset;
cpu_bus_t    bus;
logic        dtack_n;
logic [15:0] rdata;
logic [2:0]  ipl_n;
logic [7:0]  dswa, dswb;
player_t     p1, p2;
logic [1:0]  coin;
logic        vblank_n, dma_n;
logic        pixel_valid;
pal_index_t  pixel_index;
logic        rgb_valid;
rgb_t        rgb;

integer seed;
int     checks, errors, timeouts;

tb_clock #(.PERIOD(20), .RESET_CYCLES(5)) clock_gen (.clk, .reset);

f2_top #(
    .WORK_BASE(WORK_BASE_DEF), .COLOR_BASE(COLOR_BASE_DEF), .IO_BASE(IO_BASE_DEF),
    .WORK_AW(WORK_AW_DEF), .PAL_AW(PAL_AW_DEF)
) dut (
    .clk, .reset, .bus, .dtack_n, .rdata, .ipl_n,
    .dswa, .dswb, .p1, .p2, .coin, .vblank_n, .dma_n,
    .pixel_valid, .pixel_index, .rgb_valid, .rgb
);

////////////////////////////////////////////////////////////////////////////
// Reference model

function automatic logic [15:0] rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r[15:0];
endfunction

function automatic logic [22:0] word_addr(input logic [7:0] base, input logic [14:0] offset);
    return {base, offset};
endfunction

function automatic logic [15:0] merge_bytes(input logic [15:0] old, input logic [15:0] data,
                                            input logic [1:0] ds_n);
    logic [15:0] mask;
    mask = {{8{!ds_n[1]}}, {8{!ds_n[0]}}};
    return (data & mask) | (old & ~mask);
endfunction

function automatic logic [7:0] player_port(input player_t p); // Active high
    return {p.start, p.joystick[6], p.joystick[5], p.joystick[4],
            p.joystick[0], p.joystick[1], p.joystick[2], p.joystick[3]};
endfunction

function automatic logic [7:0] expected_port(input logic [2:0] offset);
    logic [7:0] b;
    b = 8'h00;
    case (offset)
        3'd0:    b = dswa;
        3'd1:    b = dswb;
        3'd2:    b = player_port(p1);
        3'd3:    b = player_port(p2);
        3'd4:    b = {2'b00, p2.start, p1.start, coin, 2'b00};
        default: b = 8'h00;
    endcase
    return ~b;
endfunction

function automatic logic [7:0] widen5(input logic [4:0] v);
    logic [7:0] x;
    x = {3'b000, v};
    return (x << 3) | (x >> 2);
endfunction

function automatic rgb_t pixel_color(input logic [15:0] w);
    rgb_t c;
    c.red   = widen5(w[4:0]);
    c.green = widen5(w[9:5]);
    c.blue  = widen5(w[14:10]);
    return c;
endfunction

////////////////////////////////////////////////////////////////////////////
// Checks and run control

task automatic compare_word(input string what, input logic [15:0] actual,
                            input logic [15:0] expected);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
    end
endtask

task automatic compare_ipl(input string what, input logic [2:0] actual,
                           input logic [2:0] expected);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("Error at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
    end
endtask

task automatic compare_rgb(input string what, input rgb_t actual, input rgb_t expected);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
    end
endtask

task automatic compare_flag(input string what, input logic actual, input logic expected);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("Error at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
    end
endtask

task automatic finish_run();
    int asserts;
    asserts = dut.checks.ipl_fails + dut.checks.dtack_fails + dut.checks.pixel_fails;
    $display("Checks: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
             checks, errors, timeouts, asserts);
    if (errors == 0 && timeouts == 0 && asserts == 0) begin
        $display("Test completed successfully");
    end else begin
        $display("Test failed");
    end
    $finish;
endtask

task automatic report_timeout(input string what);
    timeouts++;
    $display("Timed out after %0d clocks waiting for %s", TIMEOUT, what);
endtask

////////////////////////////////////////////////////////////////////////////
// Bus and pixel drivers

task automatic wait_dtack(input logic level);
    int count;
    count = 0;
    do begin
        @(negedge clk);
        count++;
    end while (dtack_n !== level && count < TIMEOUT);
    if (dtack_n !== level) begin
        report_timeout($sformatf("dtack_n to go %0b", level));
    end
endtask

task automatic bus_cycle(input logic rw, input logic [2:0] fc, input logic [22:0] addr,
                         input logic [1:0] ds_n, input logic [15:0] wdata,
                         output logic [15:0] data);
    @(posedge clk);
    bus <= '{as_n: 1'b0, rw: rw, ds_n: ds_n, fc: fc, addr: addr, wdata: wdata};
    wait_dtack(1'b0);
    data = rdata;
    @(posedge clk);
    bus <= '{as_n: 1'b1, rw: 1'b1, ds_n: 2'b11, fc: 3'b000, addr: addr, wdata: 16'h0000};
    wait_dtack(1'b1);
endtask

task automatic bus_write(input logic [22:0] addr, input logic [1:0] ds_n,
                         input logic [15:0] wdata);
    logic [15:0] unused;
    bus_cycle(1'b0, 3'b101, addr, ds_n, wdata, unused);
endtask

task automatic bus_read(input logic [22:0] addr, output logic [15:0] data);
    bus_cycle(1'b1, 3'b101, addr, 2'b00, 16'h0000, data);
endtask

task automatic irq_ack(input logic [2:0] level);
    logic [15:0] data;
    bus_cycle(1'b1, 3'b111, {20'hfffff, level}, 2'b10, 16'h0000, data);
    compare_word("IACK read data", data, 16'h0000);
endtask

task automatic wait_ipl_change(input logic [2:0] old);
    int count;
    count = 0;
    do begin
        @(negedge clk);
        count++;
    end while (ipl_n === old && count < TIMEOUT);
    if (ipl_n === old) begin
        report_timeout($sformatf("ipl_n to leave %b", old));
    end
endtask

// One pixel per clock with results two clocks behind
task automatic pixel_lookup(input pal_index_t list [$], input rgb_t colors [$]);
    int n;
    n = list.size();
    for (int k = 0; k < n + 2; k++) begin
        @(posedge clk);
        if (k < n) begin
            pixel_valid <= 1'b1;
            pixel_index <= list[k];
        end else begin
            pixel_valid <= 1'b0;
        end
        @(negedge clk);
        compare_flag("rgb_valid in burst", rgb_valid, k >= 2);
        if (k >= 2) begin
            compare_rgb($sformatf("pixel %0d", k - 2), rgb, colors[k - 2]);
        end
    end
    @(negedge clk);
    compare_flag("rgb_valid after burst", rgb_valid, 1'b0);
endtask

////////////////////////////////////////////////////////////////////////////
// Tests

task automatic test_reset();
    int          count;
    logic [15:0] q;
    count = 0;
    do begin
        @(negedge clk);
        count++;
    end while (reset && count < TIMEOUT);
    if (reset) begin
        report_timeout("reset release");
    end
    compare_ipl("ipl_n after reset", ipl_n, 3'b111);
    compare_flag("dtack_n after reset", dtack_n, 1'b1);
    compare_flag("rgb_valid after reset", rgb_valid, 1'b0);
    bus_read(word_addr(NONE_BASE, 15'h0123), q);
    compare_word("unmapped read", q, 16'h0000);
endtask

task automatic test_work_ram();
    logic [14:0] offs [16];
    logic [15:0] model [16];
    logic [15:0] w, q;
    logic [1:0]  strobe;
    for (int i = 0; i < 16; i++) begin
        offs[i]  = 15'(i * 509 + 3);
        model[i] = rand_word();
        bus_write(word_addr(WORK_BASE_DEF, offs[i]), 2'b00, model[i]);
    end
    // One lane per word while the other lane keeps its value
    for (int i = 0; i < 16; i++) begin
        w      = rand_word();
        strobe = w[0] ? 2'b01 : 2'b10;
        w      = rand_word();
        bus_write(word_addr(WORK_BASE_DEF, offs[i]), strobe, w);
        model[i] = merge_bytes(model[i], w, strobe);
    end
    for (int i = 0; i < 16; i++) begin
        bus_read(word_addr(WORK_BASE_DEF, offs[i]), q);
        compare_word($sformatf("work RAM word %h", offs[i]), q, model[i]);
    end
endtask

task automatic test_input_ports();
    logic [15:0] w, v, q;
    logic [7:0]  b;
    for (int round = 0; round < 3; round++) begin
        w = rand_word();
        v = rand_word();
        @(posedge clk);
        dswa <= w[7:0];
        dswb <= w[15:8];
        p1   <= v[10:0];
        coin <= v[12:11];
        w = rand_word();
        p2   <= w[10:0];
        for (int k = 0; k < 6; k++) begin
            bus_read(word_addr(IO_BASE_DEF, 15'(k)), q);
            b = expected_port(3'(k));
            compare_word($sformatf("input port %0d", k), q, {b, b});
        end
    end
endtask

task automatic test_palette();
    pal_index_t  idx [8];
    logic [15:0] words [8];
    logic [15:0] q;
    pal_index_t  list [$];
    rgb_t        colors [$];
    for (int i = 0; i < 8; i++) begin
        idx[i]   = 12'(i * 523 + 7);
        words[i] = rand_word();
        bus_write(word_addr(COLOR_BASE_DEF, 15'(idx[i])), 2'b00, words[i]);
    end
    for (int i = 0; i < 8; i++) begin
        bus_read(word_addr(COLOR_BASE_DEF, 15'(idx[i])), q);
        compare_word($sformatf("colour RAM entry %h", idx[i]), q, words[i]);
    end
    for (int i = 0; i < 8; i++) begin
        list.push_back(idx[i]);
        colors.push_back(pixel_color(words[i]));
    end
    list.push_back(idx[3]); // Same entry twice in a row
    colors.push_back(pixel_color(words[3]));
    list.push_back(idx[3]);
    colors.push_back(pixel_color(words[3]));
    pixel_lookup(list, colors);
    list = '{idx[5]};
    colors = '{pixel_color(words[5])};
    pixel_lookup(list, colors);
endtask

task automatic test_interrupts();
    compare_ipl("ipl_n idle", ipl_n, 3'b111);
    @(posedge clk);
    vblank_n <= 1'b0;
    wait_ipl_change(3'b111);
    compare_ipl("ipl_n after vblank", ipl_n, 3'b010);
    @(posedge clk);
    vblank_n <= 1'b1;
    dma_n    <= 1'b0;
    repeat (3) @(posedge clk);
    dma_n <= 1'b1;  // DMA finished
    wait_ipl_change(3'b010);
    compare_ipl("ipl_n after DMA end", ipl_n, 3'b001);
    irq_ack(IRQ_DMA_LEVEL);
    compare_ipl("ipl_n after level 6 ack", ipl_n, 3'b010);
    irq_ack(IRQ_VBL_LEVEL);
    compare_ipl("ipl_n after level 5 ack", ipl_n, 3'b111);
endtask

initial begin
    seed     = 32'h893b3222;
    checks   = 0;
    errors   = 0;
    timeouts = 0;
    bus      = '{as_n: 1'b1, rw: 1'b1, ds_n: 2'b11, fc: 3'b000, addr: '0, wdata: '0};
    dswa        = 8'h00;
    dswb        = 8'h00;
    p1          = '0;
    p2          = '0;
    coin        = 2'b00;
    vblank_n    = 1'b1;
    dma_n       = 1'b1;
    pixel_valid = 1'b0;
    pixel_index = '0;

    test_reset();
    test_work_ram();
    test_input_ports();
    test_palette();
    test_interrupts();
    finish_run();
end

endmodule

`default_nettype wire

//--- f2_assert.sv
`timescale 1ns/1ns
`default_nettype none

module f2_assert (
    input wire                   clk,
    input wire                   reset,
    input wire f2_pkg::cpu_bus_t bus,
    input wire                   dtack_n,
    input wire [2:0]             ipl_n,
    input wire                   pixel_valid,
    input wire                   rgb_valid
);

// Failure counts, read by the testbench at the end of the run
int ipl_fails   = 0;
int dtack_fails = 0;
int pixel_fails = 0;

ipl_idle_in_reset: assert property (
    @(posedge clk) reset && $past(reset) |-> ipl_n == 3'b111
) else begin
    ipl_fails++;
    $error("ipl_n not all ones while reset is held");
end

// No acknowledge once the CPU has let go of as_n
dtack_after_as: assert property (
    @(posedge clk) disable iff (reset) $past(bus.as_n) |-> dtack_n
) else begin
    dtack_fails++;
    $error("dtack_n low after as_n was high");
end

pixel_latency: assert property (
    @(posedge clk) disable iff (reset) rgb_valid == $past(pixel_valid, 2)
) else begin
    pixel_fails++;
    $error("rgb_valid does not follow pixel_valid by two clocks");
end

endmodule

bind f2_top f2_assert checks (
    .clk, .reset, .bus, .dtack_n, .ipl_n, .pixel_valid, .rgb_valid
);

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic reset
);

initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
end

// Synchronous reset, released on a rising edge
initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
end

endmodule

`default_nettype wire

//--- f2_top.sv
`timescale 1ns/1ns
`default_nettype none

module f2_top #(
    parameter logic [7:0] WORK_BASE  = f2_pkg::WORK_BASE_DEF,
    parameter logic [7:0] COLOR_BASE = f2_pkg::COLOR_BASE_DEF,
    parameter logic [7:0] IO_BASE    = f2_pkg::IO_BASE_DEF,
    parameter int         WORK_AW    = f2_pkg::WORK_AW_DEF,
    parameter int         PAL_AW     = f2_pkg::PAL_AW_DEF
) (
    input  wire                   clk,
    input  wire                   reset,

    input  wire f2_pkg::cpu_bus_t bus,
    output logic                  dtack_n,
    output logic [15:0]           rdata,
    output logic [2:0]            ipl_n,

    input  wire [7:0]             dswa,
    input  wire [7:0]             dswb,
    input  wire f2_pkg::player_t  p1,
    input  wire f2_pkg::player_t  p2,
    input  wire [1:0]             coin,

    input  wire                   vblank_n,
    input  wire                   dma_n,

    input  wire                   pixel_valid,
    input  wire [PAL_AW-1:0]      pixel_index,
    output logic                  rgb_valid,
    output f2_pkg::rgb_t          rgb
);

import f2_pkg::*;

bus_cycle_t  cycle;
logic [15:0] work_q, pal_q, io_q;

f2_bus_decode #(
    .WORK_BASE(WORK_BASE), .COLOR_BASE(COLOR_BASE), .IO_BASE(IO_BASE)
) bus_decode (
    .clk, .reset, .bus, .cycle
);

f2_work_ram #(.WORK_AW(WORK_AW)) work_ram (
    .clk, .cycle, .work_q
);

f2_input_ports input_ports (
    .clk, .cycle, .dswa, .dswb, .p1, .p2, .coin, .io_q
);

f2_irq_ctrl irq_ctrl (
    .clk, .reset, .cycle, .vblank_n, .dma_n, .ipl_n
);

f2_palette #(.PAL_AW(PAL_AW)) palette (
    .clk, .reset, .cycle,
    .pixel_valid, .pixel_index,
    .pal_q, .rgb_valid, .rgb
);

f2_cpu_response cpu_response (
    .clk, .reset, .bus, .cycle,
    .work_q, .pal_q, .io_q,
    .rdata, .dtack_n
);

endmodule

`default_nettype wire

//--- f2_cpu_response.sv
`timescale 1ns/1ns
`default_nettype none

module f2_cpu_response (
    input  wire                   clk,
    input  wire                   reset,
    input  wire f2_pkg::cpu_bus_t bus,
    input  wire f2_pkg::bus_cycle_t cycle,
    input  wire [15:0]            work_q,
    input  wire [15:0]            pal_q,
    input  wire [15:0]            io_q,
    output logic [15:0]           rdata,
    output logic                  dtack_n
);

import f2_pkg::*;

region_t region_q; // Lines up with the registered read words

always_ff @(posedge clk) begin
    region_q <= cycle.region;
end

always_comb begin
    case (region_q)
        REG_WORK:  rdata = work_q;
        REG_COLOR: rdata = pal_q;
        REG_IO:    rdata = io_q;
        default:   rdata = 16'h0000; // Unmapped and IACK
    endcase
end

always_ff @(posedge clk) begin
    if (reset) begin
        dtack_n <= 1'b1;
    end else if (bus.as_n) begin
        dtack_n <= 1'b1;
    end else if (cycle.valid) begin
        dtack_n <= 1'b0;
    end
end

endmodule

`default_nettype wire

//--- f2_palette.sv
`timescale 1ns/1ns
`default_nettype none

module f2_palette #(
    parameter int PAL_AW = f2_pkg::PAL_AW_DEF
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire f2_pkg::bus_cycle_t cycle,
    input  wire                   pixel_valid,
    input  wire [PAL_AW-1:0]      pixel_index,
    output logic [15:0]           pal_q,
    output logic                  rgb_valid,
    output f2_pkg::rgb_t          rgb
);

import f2_pkg::*;

palette_word_u     mem [2**PAL_AW];
logic [PAL_AW-1:0] cpu_addr;
logic              we;
palette_word_u     pix_word;
logic              pix_valid;

assign cpu_addr = cycle.offset[PAL_AW-1:0];
assign we       = cycle.valid && (cycle.region == REG_COLOR) && !cycle.rw;

////////////////////////////////////////////////////////////////////////////
// CPU port

always_ff @(posedge clk) begin
    if (we && !cycle.ds_n[1]) begin
        mem[cpu_addr].raw[15:8] <= cycle.wdata[15:8];
    end
    if (we && !cycle.ds_n[0]) begin
        mem[cpu_addr].raw[7:0] <= cycle.wdata[7:0];
    end
    pal_q <= mem[cpu_addr].raw;
end

////////////////////////////////////////////////////////////////////////////
// Video port

always_ff @(posedge clk) begin
    pix_word <= mem[pixel_index];  // Stage 1

    // Stage 2, 5 to 8 bits by repeating the top bits
    rgb.red   <= {pix_word.rgb555.red,   pix_word.rgb555.red[4:2]};
    rgb.green <= {pix_word.rgb555.green, pix_word.rgb555.green[4:2]};
    rgb.blue  <= {pix_word.rgb555.blue,  pix_word.rgb555.blue[4:2]};
end

always_ff @(posedge clk) begin
    if (reset) begin
        pix_valid <= 1'b0;
        rgb_valid <= 1'b0;
    end else begin
        pix_valid <= pixel_valid;
        rgb_valid <= pix_valid;
    end
end

endmodule

`default_nettype wire

//--- f2_irq_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module f2_irq_ctrl (
    input  wire                   clk,
    input  wire                   reset,
    input  wire f2_pkg::bus_cycle_t cycle,
    input  wire                   vblank_n,
    input  wire                   dma_n,
    output logic [2:0]            ipl_n
);

import f2_pkg::*;

logic vbl_s, vbl_p;
logic dma_s, dma_p;
logic req_vbl, req_dma;
logic ack;
logic clr_vbl, clr_dma;

assign ack     = cycle.valid && (cycle.region == REG_IACK) && !cycle.ds_n[0];
assign clr_vbl = ack && (cycle.offset[2:0] == IRQ_VBL_LEVEL);
assign clr_dma = ack && (cycle.offset[2:0] == IRQ_DMA_LEVEL);

always_ff @(posedge clk) begin
    if (reset) begin
        vbl_s   <= 1'b1;
        vbl_p   <= 1'b1;
        dma_s   <= 1'b1;
        dma_p   <= 1'b1;
        req_vbl <= 1'b0;
        req_dma <= 1'b0;
    end else begin
        vbl_s <= vblank_n;
        vbl_p <= vbl_s;
        dma_s <= dma_n;
        dma_p <= dma_s;

        if (vbl_p && !vbl_s) req_vbl <= 1'b1; // Start of vblank
        if (!dma_p && dma_s) req_dma <= 1'b1; // End of sprite DMA

        // Acknowledge beats a new edge
        if (clr_vbl) req_vbl <= 1'b0;
        if (clr_dma) req_dma <= 1'b0;
    end
end

always_comb begin
    if (req_dma) begin
        ipl_n = ~IRQ_DMA_LEVEL;
    end else if (req_vbl) begin
        ipl_n = ~IRQ_VBL_LEVEL;
    end else begin
        ipl_n = 3'b111;
    end
end

endmodule

`default_nettype wire

//--- f2_input_ports.sv
`timescale 1ns/1ns
`default_nettype none

module f2_input_ports (
    input  wire                   clk,
    input  wire f2_pkg::bus_cycle_t cycle,
    input  wire [7:0]             dswa,
    input  wire [7:0]             dswb,
    input  wire f2_pkg::player_t  p1,
    input  wire f2_pkg::player_t  p2,
    input  wire [1:0]             coin,
    output logic [15:0]           io_q
);

import f2_pkg::*;

logic [7:0] port_byte;

// Start, buttons 3..1, then right, left, down, up
function automatic logic [7:0] player_byte(player_t p);
    return ~{p.start, p.joystick[6:4],
             p.joystick[0], p.joystick[1], p.joystick[2], p.joystick[3]};
endfunction

always_ff @(posedge clk) begin
    case (cycle.offset[2:0])
        3'd0:    port_byte <= ~dswa;
        3'd1:    port_byte <= ~dswb;
        3'd2:    port_byte <= player_byte(p1);
        3'd3:    port_byte <= player_byte(p2);
        3'd4:    port_byte <= ~{2'b00, p2.start, p1.start, coin[1], coin[0], 2'b00};
        default: port_byte <= 8'hff;
    endcase
end

assign io_q = {port_byte, port_byte}; // Same byte on both lanes

endmodule

`default_nettype wire

//--- f2_work_ram.sv
`timescale 1ns/1ns
`default_nettype none

module f2_work_ram #(
    parameter int WORK_AW = f2_pkg::WORK_AW_DEF
) (
    input  wire                   clk,
    input  wire f2_pkg::bus_cycle_t cycle,
    output logic [15:0]           work_q
);

import f2_pkg::*;

logic [15:0]        mem [2**WORK_AW];
logic [WORK_AW-1:0] addr;
logic               we;

assign addr = cycle.offset[WORK_AW-1:0];
assign we   = cycle.valid && (cycle.region == REG_WORK) && !cycle.rw;

always_ff @(posedge clk) begin
    if (we && !cycle.ds_n[1]) begin
        mem[addr][15:8] <= cycle.wdata[15:8];
    end
    if (we && !cycle.ds_n[0]) begin
        mem[addr][7:0] <= cycle.wdata[7:0];
    end
    work_q <= mem[addr]; // Read every clock
end

endmodule

`default_nettype wire

//--- f2_bus_decode.sv
`timescale 1ns/1ns
`default_nettype none

module f2_bus_decode #(
    parameter logic [7:0] WORK_BASE  = f2_pkg::WORK_BASE_DEF,
    parameter logic [7:0] COLOR_BASE = f2_pkg::COLOR_BASE_DEF,
    parameter logic [7:0] IO_BASE    = f2_pkg::IO_BASE_DEF
) (
    input  wire                clk,
    input  wire                reset,
    input  wire f2_pkg::cpu_bus_t bus,
    output f2_pkg::bus_cycle_t cycle
);

import f2_pkg::*;

logic       open_q;    // Cycle accepted, waiting for as_n to rise
logic       accept;
logic [7:0] window;
region_t    region;

assign window = bus.addr[22:15]; // Byte address 23:16
assign accept = !open_q && !bus.as_n;

always_comb begin
    if (&bus.fc) begin
        region = REG_IACK;
    end else if (window == WORK_BASE) begin
        region = REG_WORK;
    end else if (window == COLOR_BASE) begin
        region = REG_COLOR;
    end else if (window == IO_BASE) begin
        region = REG_IO;
    end else begin
        region = REG_NONE;
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        open_q      <= 1'b0;
        cycle.valid <= 1'b0;
    end else begin
        cycle.valid <= accept; // One clock per cycle
        if (accept) begin
            open_q       <= 1'b1;
            cycle.region <= region;
            cycle.rw     <= bus.rw;
            cycle.ds_n   <= bus.ds_n;
            cycle.offset <= {7'd0, bus.addr[14:0]};
            cycle.wdata  <= bus.wdata;
        end else if (open_q && bus.as_n) begin
            open_q <= 1'b0;
        end
    end
end

endmodule

`default_nettype wire

//--- f2_pkg.sv
`default_nettype none

package f2_pkg;

////////////////////////////////////////////////////////////////////////////
// CPU bus

typedef struct packed {
    logic        as_n;
    logic        rw;      // High for read
    logic [1:0]  ds_n;    // Upper, lower
    logic [2:0]  fc;
    logic [22:0] addr;    // Word address
    logic [15:0] wdata;
} cpu_bus_t;

typedef enum logic [2:0] {
    REG_NONE,
    REG_WORK,
    REG_COLOR,
    REG_IO,
    REG_IACK
} region_t;

// One accepted cycle, held until the next one opens
typedef struct packed {
    logic        valid;
    region_t     region;
    logic        rw;
    logic [1:0]  ds_n;
    logic [21:0] offset;  // Level in bits 2:0 for IACK
    logic [15:0] wdata;
} bus_cycle_t;

typedef struct packed {
    logic       start;
    logic [9:0] joystick; // R, L, D, U, then buttons 1..3
} player_t;

////////////////////////////////////////////////////////////////////////////
// Palette

typedef union packed {
    logic [15:0] raw;
    struct packed {
        logic       unused;
        logic [4:0] blue;
        logic [4:0] green;
        logic [4:0] red;
    } rgb555;
} palette_word_u;

typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
} rgb_t;

// Window bases compare against address byte 23:16
localparam logic [7:0] WORK_BASE_DEF  = 8'h10;
localparam logic [7:0] COLOR_BASE_DEF = 8'h20;
localparam logic [7:0] IO_BASE_DEF    = 8'h30;

localparam int WORK_AW_DEF = 13;
localparam int PAL_AW_DEF  = 12;

localparam logic [2:0] IRQ_VBL_LEVEL = 3'd5;
localparam logic [2:0] IRQ_DMA_LEVEL = 3'd6;

endpackage

`default_nettype wire
